//--- design/rv_pkg.sv
// Shared RV32I types and constants, imported by every block of the execute subsystem
package rv_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Data width is fixed by the ISA
  localparam int unsigned XLEN = 32;

  // One data word for operands, results and register contents
  typedef logic [XLEN-1:0] word_t;

  // Register index as found in the instruction fields
  typedef logic [4:0] reg_idx_t;

  ////////////////////////////////////////
  // ALU operations
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  ////////////////////////////////////////
  // Instruction formats
  ////////////////////////////////////////

  // R-format view, register-register operations
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } instr_r_t;

  // I-format view, register-immediate operations
  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } instr_i_t;

  // Same 32-bit word seen through either format
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  // Accepted major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct7 values, base and alternate (SUB, SRA)
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

//--- design/rv_intf.sv
// Internal links of the execute subsystem: decoder to ALU, and ALU to writeback and forwarding
`timescale 1ns/1ps

////////////////////////////////////////
// Issue link
////////////////////////////////////////

interface issue_if;
  import rv_pkg::*;

  // Operation issued this cycle
  logic     valid;
  alu_op_e  op;
  // Operands after register read, forwarding or immediate selection
  word_t    operand_a;
  word_t    operand_b;
  reg_idx_t rd;
  // Set for an unsupported word, operands are then zero
  logic     illegal;

  // Decoder side
  modport src (
    output valid,
    output op,
    output operand_a,
    output operand_b,
    output rd,
    output illegal
  );

  // ALU side
  modport dst (
    input valid,
    input op,
    input operand_a,
    input operand_b,
    input rd,
    input illegal
  );

endinterface

////////////////////////////////////////
// Result link
////////////////////////////////////////

interface result_if;
  import rv_pkg::*;

  logic     valid;
  word_t    result;
  reg_idx_t rd;
  logic     illegal;

  // ALU drives the combinational result
  modport src (output valid, output result, output rd, output illegal);

  // Writeback registers it
  modport dst (input valid, input result, input rd, input illegal);

  // Decoder watches it to forward an unwritten result
  modport mon (input valid, input result, input rd, input illegal);

endinterface

//--- design/rv_decoder.sv
// Input side: decodes OP and OP-IMM words, reads and forwards operands, registers the issue
`timescale 1ns/1ps

module rv_decoder #(
  parameter int RV32E = 0
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             instr_valid_i,
  input  rv_pkg::instr_u   instr_i,
  output rv_pkg::reg_idx_t raddr_a_o,
  output rv_pkg::reg_idx_t raddr_b_o,
  input  rv_pkg::word_t    rdata_a_i,
  input  rv_pkg::word_t    rdata_b_i,
  issue_if.src             iss,
  result_if.mon            fwd
);
  import rv_pkg::*;

  // Operation selected by funct3 for base funct7
  function automatic alu_op_e base_op(input logic [2:0] funct3);
    case (funct3)
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return ALU_SRL;
      3'b110:  return ALU_OR;
      3'b111:  return ALU_AND;
      default: return ALU_ADD;
    endcase
  endfunction

  alu_op_e  op_d;
  logic     illegal_d;
  logic     use_imm;
  logic     fwd_a;
  logic     fwd_b;
  word_t    imm_sext;
  word_t    opa_d;
  word_t    opb_d;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  // I-format immediate, also carries the shift amount in its low bits
  assign imm_sext = {{(XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};

  always_comb begin
    op_d      = ALU_ADD;
    illegal_d = 1'b0;
    use_imm   = 1'b0;
    case (instr_i.r.opcode)
      OPC_OP: begin
        if (instr_i.r.funct7 == F7_BASE) begin
          op_d = base_op(instr_i.r.funct3);
        end else if (instr_i.r.funct7 == F7_ALT && instr_i.r.funct3 == 3'b000) begin
          op_d = ALU_SUB;
        end else if (instr_i.r.funct7 == F7_ALT && instr_i.r.funct3 == 3'b101) begin
          op_d = ALU_SRA;
        end else begin
          illegal_d = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        op_d    = base_op(instr_i.i.funct3);
        // Shift-immediates reuse the funct7 field above the shift amount
        if (instr_i.i.funct3 == 3'b001 && instr_i.r.funct7 != F7_BASE) begin
          illegal_d = 1'b1;
        end else if (instr_i.i.funct3 == 3'b101) begin
          if (instr_i.r.funct7 == F7_ALT) begin
            op_d = ALU_SRA;
          end else if (instr_i.r.funct7 != F7_BASE) begin
            illegal_d = 1'b1;
          end
        end
      end
      default: illegal_d = 1'b1;
    endcase
    // RV32E has only x0..x15, rs2 exists only in the R-format
    if (RV32E != 0) begin
      if (instr_i.r.rd[4] || instr_i.r.rs1[4] || (!use_imm && instr_i.r.rs2[4])) begin
        illegal_d = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Operand read and forwarding
  ////////////////////////////////////////

  assign raddr_a_o = instr_i.r.rs1;
  assign raddr_b_o = instr_i.r.rs2;

  // Producer from last cycle has not reached the register file yet
  assign fwd_a = fwd.valid && !fwd.illegal && instr_i.r.rs1 != '0 && fwd.rd == instr_i.r.rs1;
  assign fwd_b = fwd.valid && !fwd.illegal && instr_i.r.rs2 != '0 && fwd.rd == instr_i.r.rs2;

  always_comb begin
    opa_d = fwd_a ? fwd.result : rdata_a_i;
    if (use_imm) begin
      opb_d = imm_sext;
    end else begin
      opb_d = fwd_b ? fwd.result : rdata_b_i;
    end
    // Illegal words issue with zero operands
    if (illegal_d) begin
      opa_d = '0;
      opb_d = '0;
    end
  end

  ////////////////////////////////////////
  // Issue register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      iss.valid     <= 1'b0;
      iss.op        <= ALU_ADD;
      iss.operand_a <= '0;
      iss.operand_b <= '0;
      iss.rd        <= '0;
      iss.illegal   <= 1'b0;
    end else begin
      iss.valid <= instr_valid_i;
      // Payload only moves with a new word
      if (instr_valid_i) begin
        iss.op        <= op_d;
        iss.operand_a <= opa_d;
        iss.operand_b <= opb_d;
        iss.rd        <= instr_i.r.rd;
        iss.illegal   <= illegal_d;
      end
    end
  end

endmodule

//--- design/rv_register_file.sv
// Flip-flop register file, two combinational read ports and one enabled write port
`timescale 1ns/1ps

module rv_register_file #(
  parameter int RV32E = 0
) (
  input  logic             clk,
  input  logic             rst_n,
  input  rv_pkg::reg_idx_t raddr_a_i,
  input  rv_pkg::reg_idx_t raddr_b_i,
  input  rv_pkg::reg_idx_t waddr_i,
  output rv_pkg::word_t    rdata_a_o,
  output rv_pkg::word_t    rdata_b_o,
  input  rv_pkg::word_t    wdata_i,
  input  logic             we_i
);
  import rv_pkg::*;

  // RV32E keeps 16 registers, RV32I 32
  localparam int ADDR_WIDTH = (RV32E != 0) ? 4 : 5;
  localparam int NUM_WORDS  = 2 ** ADDR_WIDTH;

  // x0 has no storage
  word_t                rf_q [1:NUM_WORDS-1];
  logic [NUM_WORDS-1:1] we_dec;

  // Read one port, x0 gives zero
  function automatic word_t read_reg(input logic [ADDR_WIDTH-1:0] idx);
    if (idx == '0) begin
      return '0;
    end
    return rf_q[idx];
  endfunction

  // One-hot write enable for x1 and up
  always_comb begin
    for (int i = 1; i < NUM_WORDS; i++) begin
      we_dec[i] = we_i && (waddr_i[ADDR_WIDTH-1:0] == i[ADDR_WIDTH-1:0]);
    end
  end

  // Each register loads on its own enable bit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < NUM_WORDS; i++) begin
        rf_q[i] <= '0;
      end
    end else begin
      for (int i = 1; i < NUM_WORDS; i++) begin
        if (we_dec[i]) begin
          rf_q[i] <= wdata_i;
        end
      end
    end
  end

  assign rdata_a_o = read_reg(raddr_a_i[ADDR_WIDTH-1:0]);
  assign rdata_b_o = read_reg(raddr_b_i[ADDR_WIDTH-1:0]);

endmodule

//--- design/rv_alu.sv
// Combinational ALU: add, subtract, logic, signed and unsigned compare, shifts
`timescale 1ns/1ps

module rv_alu (
  issue_if.dst  iss,
  result_if.src res
);
  import rv_pkg::*;

  word_t      add_res;
  word_t      sub_res;
  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  word_t      result_d;

  ////////////////////////////////////////
  // Shared datapath pieces
  ////////////////////////////////////////

  assign add_res = iss.operand_a + iss.operand_b;
  assign sub_res = iss.operand_a - iss.operand_b;

  // Only the low five bits count for RV32 shifts
  assign shamt = iss.operand_b[4:0];

  assign lt_signed   = $signed(iss.operand_a) < $signed(iss.operand_b);
  assign lt_unsigned = iss.operand_a < iss.operand_b;

  ////////////////////////////////////////
  // Operation select
  ////////////////////////////////////////

  always_comb begin
    case (iss.op)
      ALU_ADD:  result_d = add_res;
      ALU_SUB:  result_d = sub_res;
      ALU_SLL:  result_d = iss.operand_a << shamt;
      // Compares give 0 or 1
      ALU_SLT:  result_d = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result_d = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:  result_d = iss.operand_a ^ iss.operand_b;
      ALU_SRL:  result_d = iss.operand_a >> shamt;
      // Arithmetic shift keeps the sign bit
      ALU_SRA:  result_d = word_t'($signed(iss.operand_a) >>> shamt);
      ALU_OR:   result_d = iss.operand_a | iss.operand_b;
      ALU_AND:  result_d = iss.operand_a & iss.operand_b;
      default:  result_d = '0;
    endcase
  end

  ////////////////////////////////////////
  // Result link
  ////////////////////////////////////////

  // Control passes straight through, zero result for an illegal word
  assign res.valid   = iss.valid;
  assign res.rd      = iss.rd;
  assign res.illegal = iss.illegal;
  assign res.result  = iss.illegal ? '0 : result_d;

endmodule

//--- design/rv_writeback.sv
// Output side: drives the register-file write and registers the result for the ports
`timescale 1ns/1ps

module rv_writeback (
  input  logic             clk,
  input  logic             rst_n,
  result_if.dst            res,
  output logic             we_o,
  output rv_pkg::reg_idx_t waddr_o,
  output rv_pkg::word_t    wdata_o,
  output logic             result_valid_o,
  output rv_pkg::word_t    result_o,
  output rv_pkg::reg_idx_t result_rd_o,
  output logic             illegal_o
);
  import rv_pkg::*;

  ////////////////////////////////////////
  // Register-file write port
  ////////////////////////////////////////

  // Write lands on the same edge that raises result_valid_o
  // x0 writes go out too, the register file has no storage for x0
  assign we_o    = res.valid && !res.illegal;
  assign waddr_o = res.rd;
  assign wdata_o = res.result;

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid_o <= 1'b0;
      result_o       <= '0;
      result_rd_o    <= '0;
      illegal_o      <= 1'b0;
    end else begin
      // Valid is a one-cycle pulse per result
      result_valid_o <= res.valid;
      illegal_o      <= res.valid && res.illegal;
      if (res.valid) begin
        result_o    <= res.result;
        result_rd_o <= res.rd;
      end
    end
  end

endmodule

//--- design/rv_exec_top.sv
// Top level of the RV32I execute subsystem, wires decoder, register file, ALU and writeback
`timescale 1ns/1ps

module rv_exec_top #(
  parameter int RV32E = 0
) (
  input  logic             clk,
  input  logic             rst_n,
  // Instruction input, one word per strobe
  input  logic             instr_valid_i,
  input  logic [31:0]      instr_i,
  // Result two edges after the strobe
  output logic             result_valid_o,
  output rv_pkg::word_t    result_o,
  output rv_pkg::reg_idx_t result_rd_o,
  output logic             illegal_o
);
  import rv_pkg::*;

  // Register-file read port
  reg_idx_t raddr_a;
  reg_idx_t raddr_b;
  word_t    rdata_a;
  word_t    rdata_b;
  // Register-file write port
  logic     rf_we;
  reg_idx_t rf_waddr;
  word_t    rf_wdata;

  issue_if  iss_if ();
  result_if res_if ();

  ////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////

  rv_decoder #(
    .RV32E (RV32E)
  ) i_decoder (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .raddr_a_o     (raddr_a),
    .raddr_b_o     (raddr_b),
    .rdata_a_i     (rdata_a),
    .rdata_b_i     (rdata_b),
    .iss           (iss_if.src),
    .fwd           (res_if.mon)
  );

  rv_register_file #(
    .RV32E (RV32E)
  ) i_register_file (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .waddr_i   (rf_waddr),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we)
  );

  rv_alu i_alu (
    .iss (iss_if.dst),
    .res (res_if.src)
  );

  rv_writeback i_writeback (
    .clk            (clk),
    .rst_n          (rst_n),
    .res            (res_if.dst),
    .we_o           (rf_we),
    .waddr_o        (rf_waddr),
    .wdata_o        (rf_wdata),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .result_rd_o    (result_rd_o),
    .illegal_o      (illegal_o)
  );

endmodule

//--- test/rv_exec_sva.sv
// Concurrent checks on the top-level result timing, attached to rv_exec_top by bind
`timescale 1ns/1ps

module rv_exec_sva (
  input logic          clk,
  input logic          rst_n,
  input logic          instr_valid_i,
  input logic          result_valid_o,
  input rv_pkg::word_t result_o,
  input logic          illegal_o
);

  ////////////////////////////////////////
  // Latency
  ////////////////////////////////////////

  // Every strobe gives a result two edges later
  a_result_follows: assert property (
    @(posedge clk) disable iff (!rst_n) instr_valid_i |-> ##2 result_valid_o
  ) else $error("result_valid_o missing two edges after instr_valid_i");

  // No result without a strobe two edges earlier
  a_no_extra_result: assert property (
    @(posedge clk) disable iff (!rst_n) !instr_valid_i |-> ##2 !result_valid_o
  ) else $error("result_valid_o raised without an instruction two edges earlier");

  ////////////////////////////////////////
  // Output values
  ////////////////////////////////////////

  // Illegal only on a valid result, and the result is zero
  a_illegal_zero: assert property (
    @(posedge clk) disable iff (!rst_n) illegal_o |-> (result_valid_o && result_o == '0)
  ) else $error("illegal_o without result_valid_o or with a nonzero result_o");

  a_reset_quiet: assert property (
    @(posedge clk) !rst_n |-> !result_valid_o
  ) else $error("result_valid_o high during reset");

endmodule

bind rv_exec_top rv_exec_sva i_sva (
  .clk            (clk),
  .rst_n          (rst_n),
  .instr_valid_i  (instr_valid_i),
  .result_valid_o (result_valid_o),
  .result_o       (result_o),
  .illegal_o      (illegal_o)
);

//--- test/tb_rv_exec.sv
// Testbench for the execute subsystem, directed and LFSR stimulus checked against a reference model
`timescale 1ns/1ps

module tb_rv_exec;
  import rv_pkg::*;

  localparam int TB_RV32E     = 0;
  localparam int RESET_CYCLES = 5;
  localparam int RANDOM_SLOTS = 400;
  // Setup, OP corners, OP-IMM corners, shift-imm corners, x0, dependent chain, illegal
  localparam int DIRECTED_SLOTS = 4 + 10 * 3 * 4 + 6 * 3 * 4 + 3 * 2 * 2 + 4 + 12 + 7;
  localparam int MAX_CYCLES     = RESET_CYCLES + DIRECTED_SLOTS + RANDOM_SLOTS + 20;
  localparam int DRAIN_CYCLES   = 8;
  localparam logic [6:0] OPCODE_REG = 7'b0110011;
  localparam logic [6:0] OPCODE_IMM = 7'b0010011;

  // One expected result, in issue order
  typedef struct packed {
    word_t    result;
    reg_idx_t rd;
    logic     illegal;
  } expect_t;

  logic        clk;
  logic        rst_n;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic        result_valid_o;
  word_t       result_o;
  reg_idx_t    result_rd_o;
  logic        illegal_o;

  word_t       shadow_q [32];
  expect_t     exp_q [$];
  expect_t     exp_front;
  logic [15:0] lfsr_q;
  int          cycle_cnt;

  rv_exec_top #(
    .RV32E (TB_RV32E)
  ) i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .result_rd_o    (result_rd_o),
    .illegal_o      (illegal_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////
  // Failure and compare tasks
  ////////////////////////////////////////

  task automatic stop_run();
    $display("TB FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Executes one word on the shadow registers in program order
  function automatic expect_t ref_exec(input logic [31:0] w);
    expect_t  e;
    reg_idx_t rd;
    word_t    a;
    word_t    b;
    word_t    r;
    logic     ill;
    logic     alt;
    rd  = w[11:7];
    a   = shadow_q[w[19:15]];
    b   = '0;
    ill = 1'b0;
    alt = 1'b0;
    if (w[6:0] == OPCODE_REG) begin
      b   = shadow_q[w[24:20]];
      alt = (w[31:25] == 7'h20);
      // Only SUB and SRA use the alternate funct7
      if (w[31:25] != 7'h00 && !(alt && (w[14:12] == 3'd0 || w[14:12] == 3'd5))) begin
        ill = 1'b1;
      end
    end else if (w[6:0] == OPCODE_IMM) begin
      b   = {{20{w[31]}}, w[31:20]};
      alt = (w[14:12] == 3'd5) && (w[31:25] == 7'h20);
      if (w[14:12] == 3'd1 && w[31:25] != 7'h00) begin
        ill = 1'b1;
      end
      if (w[14:12] == 3'd5 && w[31:25] != 7'h00 && w[31:25] != 7'h20) begin
        ill = 1'b1;
      end
    end else begin
      ill = 1'b1;
    end
    // RV32E knows x0..x15 only
    if (TB_RV32E != 0 && (rd[4] || w[19] || (w[6:0] == OPCODE_REG && w[24]))) begin
      ill = 1'b1;
    end
    case (w[14:12])
      3'd0:    r = alt ? a - b : a + b;
      3'd1:    r = a << b[4:0];
      3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    r = (a < b) ? 32'd1 : 32'd0;
      3'd4:    r = a ^ b;
      // Arithmetic shift fills the vacated bits with the sign
      3'd5:    r = (a >> b[4:0]) | ((alt && a[31]) ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'h0);
      3'd6:    r = a | b;
      default: r = a & b;
    endcase
    if (ill) begin
      r = '0;
    end else if (rd != 5'd0) begin
      shadow_q[rd] = r;
    end
    e.result  = r;
    e.rd      = rd;
    e.illegal = ill;
    return e;
  endfunction

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw(input int nbits, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < nbits; k++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                        input reg_idx_t rs1, input logic [2:0] f3,
                                        input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPCODE_REG};
  endfunction

  // OP index 0..7 by funct3, 8 is SUB, 9 is SRA
  function automatic logic [31:0] enc_op(input logic [3:0] k, input reg_idx_t rs2,
                                         input reg_idx_t rs1, input reg_idx_t rd);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = (k < 4'd8) ? k[2:0] : ((k == 4'd8) ? 3'd0 : 3'd5);
    f7 = (k < 4'd8) ? 7'h00 : 7'h20;
    return enc_r(f7, rs2, rs1, f3, rd);
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                        input logic [2:0] f3, input reg_idx_t rd);
    return {imm, rs1, f3, rd, OPCODE_IMM};
  endfunction

  // Drive one slot on the rising edge, queue the expected result for a valid word
  task automatic drive(input logic valid, input logic [31:0] w);
    @(posedge clk);
    instr_valid_i <= valid;
    instr_i       <= w;
    if (valid) begin
      exp_q.push_back(ref_exec(w));
    end
  endtask

  task automatic issue(input logic [31:0] w);
    drive(1'b1, w);
  endtask

  task automatic idle();
    drive(1'b0, 32'h0);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic run_directed();
    logic [11:0] imm;
    logic [2:0]  f3;
    // Corner registers x1 zero, x2 all ones, x3 most negative, x4 shift of 31
    issue(enc_i(12'h000, 5'd0, 3'd0, 5'd1));
    issue(enc_i(12'hFFF, 5'd0, 3'd0, 5'd2));
    issue(enc_i(12'h01F, 5'd2, 3'd1, 5'd3));
    issue(enc_i(12'h01F, 5'd0, 3'd0, 5'd4));
    // Every OP operation on each pair of corner registers
    for (int k = 0; k < 10; k++) begin
      for (int a = 1; a <= 3; a++) begin
        for (int b = 1; b <= 4; b++) begin
          issue(enc_op(4'(k), 5'(b), 5'(a), 5'd6));
        end
      end
    end
    // Non-shift OP-IMM against corner immediates
    for (int f = 0; f < 8; f++) begin
      if (f != 1 && f != 5) begin
        for (int a = 1; a <= 3; a++) begin
          for (int j = 0; j < 4; j++) begin
            imm = (j == 0) ? 12'h000 : (j == 1) ? 12'hFFF : (j == 2) ? 12'h800 : 12'h7FF;
            issue(enc_i(imm, 5'(a), 3'(f), 5'd6));
          end
        end
      end
    end
    // SLLI, SRLI, SRAI by 0 and 31
    for (int s = 0; s < 3; s++) begin
      for (int a = 2; a <= 3; a++) begin
        for (int sh = 0; sh < 2; sh++) begin
          f3  = (s == 0) ? 3'd1 : 3'd5;
          imm = {(s == 2) ? 7'h20 : 7'h00, sh[0] ? 5'd31 : 5'd0};
          issue(enc_i(imm, 5'(a), f3, 5'd6));
        end
      end
    end
    // x0 keeps zero, read back by forwarding candidate and by register file
    issue(enc_i(12'd5, 5'd0, 3'd0, 5'd0));
    issue(enc_op(4'd0, 5'd0, 5'd0, 5'd7));
    idle();
    issue(enc_op(4'd0, 5'd2, 5'd0, 5'd7));
    // Dependent chain through forwarding
    issue(enc_i(12'd3, 5'd0, 3'd0, 5'd8));
    for (int n = 0; n < 3; n++) begin
      issue(enc_i(12'd5, 5'd8, 3'd0, 5'd8));
    end
    issue(enc_op(4'd0, 5'd8, 5'd8, 5'd9));
    issue(enc_op(4'd8, 5'd8, 5'd9, 5'd9));
    // Producer one slot back, read from the register file
    issue(enc_i(12'd100, 5'd0, 3'd0, 5'd10));
    idle();
    issue(enc_op(4'd0, 5'd10, 5'd10, 5'd11));
    // x12 from the register file and x13 forwarded in the same read
    issue(enc_i(12'hFF9, 5'd0, 3'd0, 5'd12));
    issue(enc_i(12'd9, 5'd0, 3'd0, 5'd13));
    issue(enc_op(4'd2, 5'd13, 5'd12, 5'd14));
    // Illegal words aimed at x15, which must keep 77
    issue(enc_i(12'd77, 5'd0, 3'd0, 5'd15));
    issue({20'h12345, 5'd15, 7'b1111111});
    issue(enc_r(7'h01, 5'd2, 5'd2, 3'd0, 5'd15));
    issue(enc_i({7'h20, 5'd3}, 5'd2, 3'd1, 5'd15));
    issue(enc_op(4'd0, 5'd0, 5'd15, 5'd16));
    idle();
    issue(enc_op(4'd0, 5'd15, 5'd15, 5'd16));
  endtask

  ////////////////////////////////////////
  // Random stream
  ////////////////////////////////////////

  task automatic random_word(output logic [31:0] w);
    logic [31:0] kind;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] f;
    logic [31:0] bits;
    logic [6:0]  top;
    draw(2, kind);
    // Registers x0..x7 only, so results get reused often
    draw(3, rd);
    draw(3, rs1);
    draw(3, rs2);
    draw(4, f);
    draw(12, bits);
    if (kind[1] == 1'b0) begin
      // Codes 10..15 carry an arbitrary funct7
      if (f[3:0] < 4'd10) begin
        w = enc_op(f[3:0], rs2[4:0], rs1[4:0], rd[4:0]);
      end else begin
        w = enc_r(bits[6:0], rs2[4:0], rs1[4:0], f[2:0], rd[4:0]);
      end
    end else if (kind[0] == 1'b0) begin
      // Shift-immediates get mostly legal upper bits
      if (f[1:0] == 2'b01) begin
        top        = (bits[10:8] == 3'b111) ? 7'h41 : (bits[11] ? 7'h20 : 7'h00);
        bits[11:5] = top;
      end
      w = enc_i(bits[11:0], rs1[4:0], f[2:0], rd[4:0]);
    end else begin
      // Any word, mostly an unknown opcode
      draw(32, w);
    end
  endtask

  task automatic run_random();
    logic [31:0] v;
    logic [31:0] w;
    for (int n = 0; n < RANDOM_SLOTS; n++) begin
      draw(1, v);
      random_word(w);
      drive(v[0], w);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence, compare and timeout
  ////////////////////////////////////////

  initial begin
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    lfsr_q        = 16'd94;
    cycle_cnt     = 0;
    for (int r = 0; r < 32; r++) begin
      shadow_q[r] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    run_directed();
    run_random();
    @(posedge clk);
    instr_valid_i <= 1'b0;
    // Drain the pipe, the last result trails the last word by two edges
    for (int n = 0; n < DRAIN_CYCLES && exp_q.size() != 0; n++) begin
      @(posedge clk);
    end
    // Extra edges to catch a stray result
    repeat (4) @(posedge clk);
    if (exp_q.size() == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("Expected results were left over without a matching result_valid_o");
      stop_run();
    end
  end

  // Outputs sampled on the falling edge, away from the driving edge
  always @(negedge clk) begin
    if (rst_n && result_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("result_valid_o went high at %0t with no instruction outstanding", $time);
        stop_run();
      end else begin
        exp_front = exp_q.pop_front();
        check_word("result_o", result_o, exp_front.result);
        check_idx("result_rd_o", result_rd_o, exp_front.rd);
        check_flag("illegal_o", illegal_o, exp_front.illegal);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout, the run went past %0d cycles", MAX_CYCLES);
      stop_run();
    end
  end

endmodule

//--- src.f
design/rv_pkg.sv
design/rv_intf.sv
design/rv_decoder.sv
design/rv_register_file.sv
design/rv_alu.sv
design/rv_writeback.sv
design/rv_exec_top.sv
test/rv_exec_sva.sv
test/tb_rv_exec.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and decide the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_rv_exec -f src.f --Mdir obj_dir \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_rv_exec > sim.log 2>&1
grep -q "^TB PASSED$" sim.log && echo "Simulation passed" || { cat sim.log; exit 1; }
